//--- bench/striped_link_vectors.txt
// key count stall flags, all hex
// flags bit 0 flush before the test, bit 1 stall the drain mid-run
00 0010 0000 0
5a 0040 0000 0
3c 0100 0320 2
a7 0120 0000 0
11 0020 0000 1
ff 0008 0000 1
80 0044 0190 3

//--- filelist.f
rtl/link_pkg.sv
rtl/fifo_bus.sv
rtl/lane_if.sv
rtl/byte_fifo.sv
rtl/fifo_bus_fifo_mock.sv
rtl/lane_dispatcher.sv
rtl/cipher_lane.sv
rtl/lane_collector.sv
rtl/striped_link_top.sv
bench/striped_link_tb.sv

//--- Makefile
TOP = striped_link_tb

all: run

build:
	verilator --binary --timing -j 0 -f filelist.f --top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^TEST PASSED$$" sim.log

lint:
	verilator --lint-only --timing -f filelist.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean

//--- bench/striped_link_tb.sv
`default_nettype none

module striped_link_tb import link_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int MAX_TESTS = 16;
    localparam int QUIET_CYCLES = 64;   // window after each test in which no byte may appear

    logic clk = 1'b0;
    logic reset = 1'b1;
    logic flush = 1'b0;
    logic rx_fill_enabled = 1'b0;
    logic tx_drain_enabled = 1'b0;
    logic [7:0] key = 8'h00;
    logic tx_valid;
    logic [7:0] tx_byte;

    logic [31:0] vec [4*MAX_TESTS];   // key, count, stall, flags per test
    int num_tests = 0;
    int limit = 2000;
    int cycles = 0;
    integer seed = 32'he4b1f031;

    logic in_test = 1'b0;
    int test_no = 0;
    int got = 0;        // bytes delivered since reset
    int got_end = 0;
    int made = 0;       // bytes written by the bridge generator
    int made_end = 0;
    logic [7:0] gen_ref = 8'h01;
    int err_value = 0;
    int err_flow = 0;

    striped_link_top dut_i (
        .clk(clk),
        .reset(reset),
        .flush(flush),
        .rx_fill_enabled(rx_fill_enabled),
        .tx_drain_enabled(tx_drain_enabled),
        .key(key),
        .tx_valid(tx_valid),
        .tx_byte(tx_byte)
    );

    always #4 clk = ~clk;

    task automatic check_byte(input logic [7:0] actual, input logic [7:0] expected,
                              input string what);
        if (actual !== expected) begin
            err_value++;
            $display("Fail %0t: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    //////////////////////////////
    // output monitor samples on the falling edge

    always @(negedge clk) begin
        if (reset || flush) begin
            gen_ref = 8'h01;   // generator restarts from its first byte
        end
        if (dut_i.bridge_i.rx_write) begin
            made++;
        end
        if (tx_valid === 1'b1) begin
            if (!in_test) begin
                err_flow++;
                $display("%0t: a byte came out while no test was running", $time);
            end else if (got >= got_end) begin
                err_flow++;
                $display("%0t: test %0d delivered more bytes than it asked for", $time, test_no);
            end else begin
                check_byte(tx_byte, gen_ref + key, $sformatf("test %0d byte %0d", test_no, got));
                gen_ref++;
                got++;
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > limit) begin
            $display("timeout after %0d cycles, the link stopped delivering bytes", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    //////////////////////////////
    // one line of the vector file

    task automatic run_test(input int t);
        int n;
        int stall;
        int stall_at;
        int cyc;
        logic [7:0] flags;
        n = vec[4*t+1];
        stall = vec[4*t+2];
        flags = vec[4*t+3][7:0];
        @(posedge clk);
        key <= vec[4*t][7:0];   // link is idle here
        test_no = t;
        got_end = got + n;
        in_test = 1'b1;
        if (flags[0]) begin
            @(posedge clk);
            flush <= 1'b1;
            @(posedge clk);
            flush <= 1'b0;
        end
        stall_at = flags[1] ? 10 + $unsigned($random(seed)) % n : -1;
        @(posedge clk);
        made_end = made + n;
        rx_fill_enabled <= 1'b1;
        cyc = 0;
        while (got < got_end) begin
            @(posedge clk);
            cyc++;
            if (made >= made_end) begin
                rx_fill_enabled <= 1'b0;   // the generator has produced all n bytes
            end
            if (cyc == stall_at) begin
                tx_drain_enabled <= 1'b0;
            end
            if (cyc == stall_at + stall) begin
                tx_drain_enabled <= 1'b1;
            end
        end
        repeat (QUIET_CYCLES) @(posedge clk);
        in_test = 1'b0;
    endtask

    initial begin
        for (int i = 0; i < 4*MAX_TESTS; i++) begin
            vec[i] = '0;
        end
        $readmemh("bench/striped_link_vectors.txt", vec);
        // a zero byte count marks the end of the list
        while (num_tests < MAX_TESTS && vec[4*num_tests+1] != 0) begin
            limit += vec[4*num_tests+1] * (DRAIN_RATE + 1) * 4 + vec[4*num_tests+2];
            limit += QUIET_CYCLES + 20;
            num_tests++;
        end
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        tx_drain_enabled <= 1'b1;
        repeat (20) @(posedge clk);   // fill still off, tx_valid has to stay low
        for (int t = 0; t < num_tests; t++) begin
            run_test(t);
        end
        $display("%0d tests, %0d wrong bytes, %0d flow errors", num_tests, err_value, err_flow);
        if (err_value == 0 && err_flow == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- rtl/striped_link_top.sv
`default_nettype none

module striped_link_top import link_pkg::*; (
    input wire logic clk,
    input wire logic reset,
    input wire logic flush,

    input wire logic rx_fill_enabled,
    input wire logic tx_drain_enabled,
    input wire logic [7:0] key,

    output logic tx_valid,
    output logic [7:0] tx_byte
);

    fifo_bus bus_if ();
    lane_if lane_ifs [NUM_LANES] ();

    fifo_bus_fifo_mock #(
        .DEPTH(BRIDGE_DEPTH),
        .FILL_RATE(FILL_RATE),
        .DRAIN_RATE(DRAIN_RATE)
    ) bridge_i (
        .clk(clk),
        .reset(reset),
        .flush(flush),
        .rx_fill_enabled(rx_fill_enabled),
        .tx_drain_enabled(tx_drain_enabled),
        .bus(bus_if.fifo),
        .tx_valid(tx_valid),
        .tx_byte(tx_byte)
    );

    lane_dispatcher dispatcher_i (
        .clk(clk),
        .reset(reset),
        .bus(bus_if.host),
        .lanes(lane_ifs)
    );

    generate
        for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
            cipher_lane lane_i (
                .clk(clk),
                .reset(reset),
                .key(key),
                .link(lane_ifs[i])
            );
        end
    endgenerate

    lane_collector collector_i (
        .clk(clk),
        .reset(reset),
        .lanes(lane_ifs),
        .bus(bus_if.host)
    );

endmodule

`default_nettype wire

//--- rtl/lane_collector.sv
`default_nettype none

module lane_collector import link_pkg::*; (
    input wire logic clk,
    input wire logic reset,

    lane_if.collect lanes [NUM_LANES],
    fifo_bus.host bus
);

    lane_idx_t ptr;
    logic [NUM_LANES-1:0] head_valid;
    logic [7:0] head_data [NUM_LANES];
    logic take;

    generate
        for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
            assign head_valid[i] = lanes[i].out_valid;
            assign head_data[i] = lanes[i].out_data;
            assign lanes[i].out_pop = take && ptr == lane_idx_t'(i);
        end
    endgenerate

    // same order as the dispatcher, so the stream comes back in sequence
    assign take = head_valid[ptr] && !bus.tx_full;
    assign bus.tx_write = take;
    assign bus.tx_wdata = head_data[ptr];

    always_ff @(posedge clk) begin
        if (reset) begin
            ptr <= '0;
        end else if (take) begin
            ptr <= (ptr == lane_idx_t'(NUM_LANES - 1)) ? '0 : ptr + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- rtl/cipher_lane.sv
`default_nettype none

module cipher_lane import link_pkg::*; (
    input wire logic clk,
    input wire logic reset,
    input wire logic [7:0] key,

    lane_if.lane link
);

    logic sum_valid;
    logic [7:0] sum_data;
    logic buf_empty;

    always_ff @(posedge clk) begin
        if (reset) begin
            sum_valid <= 1'b0;
        end else begin
            sum_valid <= link.in_valid;
        end
    end

    always_ff @(posedge clk) begin
        sum_data <= link.in_data + key;   // carry out drops, so modulo 256
    end

    // credits keep this buffer from ever overflowing
    byte_fifo #(.DEPTH(LANE_DEPTH)) lane_buf (
        .clk(clk),
        .reset(reset),
        .flush(1'b0),
        .write(sum_valid),
        .wdata(sum_data),
        .full(),
        .read(link.out_pop),
        .rdata(link.out_data),
        .empty(buf_empty),
        .count()
    );

    assign link.out_valid = !buf_empty;

    always_ff @(posedge clk) begin
        if (reset) begin
            link.credit <= 1'b0;
        end else begin
            link.credit <= link.out_pop;
        end
    end

endmodule

`default_nettype wire

//--- rtl/lane_dispatcher.sv
`default_nettype none

module lane_dispatcher import link_pkg::*; (
    input wire logic clk,
    input wire logic reset,

    fifo_bus.host bus,
    lane_if.dispatch lanes [NUM_LANES]
);

    lane_idx_t ptr;
    logic [NUM_LANES-1:0] has_credit;
    logic send;

    // RX pop and lane write go out in the same cycle
    assign send = !bus.rx_empty && has_credit[ptr];
    assign bus.rx_read = send;

    generate
        for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
            logic [CREDIT_BITS-1:0] credits;
            logic take;

            assign take = send && ptr == lane_idx_t'(i);
            assign has_credit[i] = credits != '0;
            assign lanes[i].in_valid = take;
            assign lanes[i].in_data = bus.rx_rdata;

            always_ff @(posedge clk) begin
                if (reset) begin
                    credits <= CREDIT_BITS'(LANE_DEPTH);
                end else begin
                    credits <= credits - CREDIT_BITS'(take) + CREDIT_BITS'(lanes[i].credit);
                end
            end
        end
    endgenerate

    always_ff @(posedge clk) begin
        if (reset) begin
            ptr <= '0;
        end else if (send) begin
            ptr <= (ptr == lane_idx_t'(NUM_LANES - 1)) ? '0 : ptr + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- rtl/fifo_bus_fifo_mock.sv
`default_nettype none

module fifo_bus_fifo_mock #(
    parameter int DEPTH = 64,
    parameter int FILL_RATE = 2,
    parameter int DRAIN_RATE = 3
) (
    input wire logic clk,
    input wire logic reset,
    input wire logic flush,

    input wire logic rx_fill_enabled,
    input wire logic tx_drain_enabled,

    fifo_bus.fifo bus,

    output logic tx_valid,
    output logic [7:0] tx_byte
);

    ///////////////////////////////
    // paced byte generator on the RX side

    logic rx_fill;
    logic rx_full;
    logic rx_write;
    logic [7:0] rx_wdata;

    byte_fifo #(.DEPTH(DEPTH)) rx_fifo (
        .clk(clk),
        .reset(reset),
        .flush(flush),
        .write(rx_write),
        .wdata(rx_wdata),
        .full(rx_full),
        .read(bus.rx_read),
        .rdata(bus.rx_rdata),
        .empty(bus.rx_empty),
        .count()
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            rx_fill <= 1'b0;
        end else begin
            rx_fill <= rx_fill_enabled;
        end
    end

    generate
        if (FILL_RATE == 0) begin : g_fill_free
            assign rx_write = rx_fill && !rx_full;
        end else begin : g_fill_paced
            localparam int FILL_BITS = $clog2(FILL_RATE + 1);
            logic [FILL_BITS-1:0] fill_wait;

            assign rx_write = rx_fill && !rx_full && fill_wait == FILL_BITS'(FILL_RATE);

            always_ff @(posedge clk) begin
                if (reset || flush || rx_write) begin
                    fill_wait <= '0;
                end else if (fill_wait != FILL_BITS'(FILL_RATE)) begin
                    fill_wait <= fill_wait + 1'b1;
                end
            end
        end
    endgenerate

    // incrementing stream that wraps through 8'h00
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            rx_wdata <= 8'h01;
        end else if (rx_write) begin
            rx_wdata <= rx_wdata + 8'h01;
        end
    end

    ///////////////////////////////
    // paced drain of the TX side

    logic tx_drain;
    logic tx_empty;
    logic tx_read;
    logic [7:0] tx_rdata;

    byte_fifo #(.DEPTH(DEPTH)) tx_fifo (
        .clk(clk),
        .reset(reset),
        .flush(flush),
        .write(bus.tx_write),
        .wdata(bus.tx_wdata),
        .full(bus.tx_full),
        .read(tx_read),
        .rdata(tx_rdata),
        .empty(tx_empty),
        .count()
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            tx_drain <= 1'b0;
        end else begin
            tx_drain <= tx_drain_enabled;
        end
    end

    generate
        if (DRAIN_RATE == 0) begin : g_drain_free
            assign tx_read = tx_drain && !tx_empty;
        end else begin : g_drain_paced
            localparam int DRAIN_BITS = $clog2(DRAIN_RATE + 1);
            logic [DRAIN_BITS-1:0] drain_wait;

            assign tx_read = tx_drain && !tx_empty && drain_wait == DRAIN_BITS'(DRAIN_RATE);

            always_ff @(posedge clk) begin
                if (reset || flush || tx_read) begin
                    drain_wait <= '0;
                end else if (drain_wait != DRAIN_BITS'(DRAIN_RATE)) begin
                    drain_wait <= drain_wait + 1'b1;
                end
            end
        end
    endgenerate

    always_ff @(posedge clk) begin
        if (reset) begin
            tx_valid <= 1'b0;
        end else begin
            tx_valid <= tx_read;
        end
    end

    always_ff @(posedge clk) begin
        if (tx_read) begin
            tx_byte <= tx_rdata;   // held until the next drained byte
        end
    end

endmodule

`default_nettype wire

//--- rtl/byte_fifo.sv
`default_nettype none

module byte_fifo #(
    parameter int DEPTH = 16
) (
    input wire logic clk,
    input wire logic reset,
    input wire logic flush,

    input wire logic write,
    input wire logic [7:0] wdata,
    output logic full,

    input wire logic read,
    output logic [7:0] rdata,
    output logic empty,

    output logic [$clog2(DEPTH):0] count
);

    localparam int PTR_BITS = $clog2(DEPTH);

    logic [7:0] mem [DEPTH];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic do_write;
    logic do_read;

    assign full = count == (PTR_BITS + 1)'(DEPTH);
    assign empty = count == '0;
    assign rdata = mem[rd_ptr];   // fall-through head

    assign do_write = write && !full;
    assign do_read = read && !empty;

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_ptr] <= wdata;
        end
    end

    // pointers wrap on their own since DEPTH is a power of two
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + (PTR_BITS + 1)'(do_write) - (PTR_BITS + 1)'(do_read);
        end
    end

endmodule

`default_nettype wire

//--- rtl/lane_if.sv
`default_nettype none

interface lane_if;

    logic in_valid;
    logic [7:0] in_data;
    logic credit;       // one pulse per byte that left the lane buffer

    logic out_valid;
    logic [7:0] out_data;
    logic out_pop;

    modport dispatch (
        output in_valid, in_data,
        input credit
    );

    modport lane (
        input in_valid, in_data, out_pop,
        output credit, out_valid, out_data
    );

    modport collect (
        input out_valid, out_data,
        output out_pop
    );

endinterface

`default_nettype wire

//--- rtl/fifo_bus.sv
`default_nettype none

// byte-wide FIFO bus as presented by the bridge chip
interface fifo_bus;

    logic rx_empty;
    logic [7:0] rx_rdata;   // head of RX while rx_empty is low
    logic rx_read;

    logic tx_full;
    logic tx_write;
    logic [7:0] tx_wdata;

    modport fifo (
        output rx_empty, rx_rdata, tx_full,
        input rx_read, tx_write, tx_wdata
    );

    modport host (
        input rx_empty, rx_rdata, tx_full,
        output rx_read, tx_write, tx_wdata
    );

endinterface

`default_nettype wire

//--- rtl/link_pkg.sv
`default_nettype none

package link_pkg;

    ///////////////////////////////
    // lane striping

    localparam int NUM_LANES = 4;
    localparam int LANE_BITS = $clog2(NUM_LANES);

    // each lane buffer starts out fully credited to the dispatcher
    localparam int LANE_DEPTH = 4;
    localparam int CREDIT_BITS = $clog2(LANE_DEPTH + 1);

    ///////////////////////////////
    // bridge mock

    localparam int BRIDGE_DEPTH = 64;
    localparam int FILL_RATE = 2;    // idle cycles between generator writes
    localparam int DRAIN_RATE = 3;   // idle cycles between TX pops

    // names one of the cipher lanes
    typedef logic [LANE_BITS-1:0] lane_idx_t;

endpackage

`default_nettype wire
